// ==== verilog/tl_pkg.sv ====
`default_nettype none

package tl_pkg;
	// channel A opcodes
	localparam logic [2:0] opcode_a_putfull    = 3'd0;
	localparam logic [2:0] opcode_a_putpartial = 3'd1;
	localparam logic [2:0] opcode_a_arithmetic = 3'd2; // TL-UH only
	localparam logic [2:0] opcode_a_logical    = 3'd3; // TL-UH only
	localparam logic [2:0] opcode_a_get        = 3'd4;
	localparam logic [2:0] opcode_a_intent     = 3'd5; // TL-UH only

	// channel D opcodes
	localparam logic [2:0] opcode_d_accessack     = 3'd0;
	localparam logic [2:0] opcode_d_accessackdata = 3'd1;
	localparam logic [2:0] opcode_d_hintack       = 3'd2;

	localparam int tl_size_width = 4;
	localparam int tl_data_width = 32;
	localparam int tl_mask_width = 4;
	localparam int tl_addr_width = 32;

	localparam int max_size_log2 = 6; // 64 bytes, 16 beats

	// register block byte offsets
	localparam logic [4:0] reg_ctrl      = 5'h00;
	localparam logic [4:0] reg_wait      = 5'h04;
	localparam logic [4:0] reg_get_count = 5'h08;
	localparam logic [4:0] reg_put_count = 5'h0c;
	localparam logic [4:0] reg_err_count = 5'h10;

	localparam logic [1:0] axi_resp_okay   = 2'd0;
	localparam logic [1:0] axi_resp_slverr = 2'd2;
endpackage

`default_nettype wire

// ==== verilog/tl_mem_array.sv ====
`default_nettype none

module tl_mem_array import tl_pkg::*; #(
	parameter int mem_words = 1024
) (
	input  logic                         clock,
	input  logic                         en,
	input  logic                         we,
	input  logic [$clog2(mem_words)-1:0] addr,
	input  logic [tl_mask_width-1:0]     wmask,
	input  logic [tl_data_width-1:0]     wdata,
	output logic [tl_data_width-1:0]     rdata
);
	logic [tl_data_width-1:0] mem [mem_words];

	// rdata only moves on a read, so it holds while a D beat is stalled
	always_ff @(posedge clock) begin
		if (en) begin
			if (we) begin
				for (int i = 0; i < tl_mask_width; i++) begin
					if (wmask[i])
						mem[addr][8*i +: 8] <= wdata[8*i +: 8];
				end
			end else begin
				rdata <= mem[addr];
			end
		end
	end
endmodule

`default_nettype wire

// ==== verilog/tl_ul_slave.sv ====
`default_nettype none

module tl_ul_slave import tl_pkg::*; #(
	parameter int mem_words    = 1024,
	parameter int source_width = 4
) (
	input  logic                         clock,
	input  logic                         reset,

	input  logic                         a_valid,
	output logic                         a_ready,
	input  logic [2:0]                   a_opcode,
	input  logic [tl_size_width-1:0]     a_size,
	input  logic [source_width-1:0]      a_source,
	input  logic [tl_addr_width-1:0]     a_address,
	input  logic [tl_mask_width-1:0]     a_mask,
	input  logic [tl_data_width-1:0]     a_data,

	output logic                         d_valid,
	input  logic                         d_ready,
	output logic [2:0]                   d_opcode,
	output logic [tl_size_width-1:0]     d_size,
	output logic [source_width-1:0]      d_source,
	output logic [tl_data_width-1:0]     d_data,
	output logic                         d_error,

	input  logic                         enable,
	input  logic [3:0]                   wait_states,

	output logic                         mem_en,
	output logic                         mem_we,
	output logic [$clog2(mem_words)-1:0] mem_addr,
	output logic [tl_mask_width-1:0]     mem_wmask,
	output logic [tl_data_width-1:0]     mem_wdata,
	input  logic [tl_data_width-1:0]     mem_rdata,

	output logic                         get_done,
	output logic                         put_done,
	output logic                         err_done
);
	localparam int mem_addr_width = $clog2(mem_words);
	localparam int beat_width = (1 << tl_size_width) - 3; // beats - 1 for the largest size field
	localparam int unsigned mem_bytes = mem_words * 4;

	typedef enum logic [2:0] {
		ph_idle,
		ph_collect,
		ph_wait,
		ph_fetch,
		ph_respond
	} phase_t;

	phase_t phase, start_phase;
	logic [beat_width-1:0] beat;
	logic [3:0] wait_cnt;

	logic [2:0] req_opcode;
	logic [tl_size_width-1:0] req_size;
	logic [source_width-1:0] req_source;
	logic [tl_addr_width-1:0] req_addr;
	logic req_err;

	logic a_fire, d_fire, d_last, start_new, a_err, rd_ok;
	logic [tl_addr_width-1:0] beat_addr;

	function automatic logic [beat_width-1:0] beats_m1(input logic [tl_size_width-1:0] size);
		if (size <= 2)
			return '0;
		return beat_width'((1 << (size - 2)) - 1);
	endfunction

	function automatic logic is_put(input logic [2:0] op);
		return op == opcode_a_putfull || op == opcode_a_putpartial;
	endfunction

	function automatic logic a_has_data(input logic [2:0] op);
		return is_put(op) || op == opcode_a_arithmetic || op == opcode_a_logical;
	endfunction

	function automatic logic d_has_data(input logic [2:0] op);
		return op == opcode_a_get || op == opcode_a_arithmetic || op == opcode_a_logical;
	endfunction

	function automatic logic check_err(input logic [2:0] op, input logic [tl_size_width-1:0] size,
			input logic [tl_addr_width-1:0] addr);
		logic [tl_addr_width:0] span_end;
		span_end = {1'b0, addr} + ({{tl_addr_width{1'b0}}, 1'b1} << size);
		if (!is_put(op) && op != opcode_a_get)
			return 1'b1; // TL-UH and unknown opcodes
		if (size > max_size_log2)
			return 1'b1;
		return span_end > mem_bytes;
	endfunction

	assign a_fire = a_valid && a_ready;
	assign d_fire = d_valid && d_ready;
	assign d_last = beat == (d_has_data(req_opcode) ? beats_m1(req_size) : '0);
	assign start_new = a_fire && phase != ph_collect;
	assign a_err = check_err(a_opcode, a_size, a_address);
	assign start_phase = (wait_states == 4'd0) ? ph_fetch : ph_wait;
	assign rd_ok = req_opcode == opcode_a_get && !req_err;

	// new request also accepted on the final D handshake
	assign a_ready = !reset && ((enable && (phase == ph_idle
		|| (phase == ph_respond && d_ready && d_last))) || phase == ph_collect);
	assign d_valid = phase == ph_respond;

	assign beat_addr = req_addr + {beat, 2'b00};
	assign mem_addr = start_new ? a_address[mem_addr_width+1:2] : beat_addr[mem_addr_width+1:2];
	assign mem_wmask = a_mask;
	assign mem_wdata = a_data;
	assign mem_we = start_new ? (a_fire && is_put(a_opcode) && !a_err)
		: (a_fire && is_put(req_opcode) && !req_err);
	assign mem_en = mem_we || (phase == ph_fetch && rd_ok);

	always_comb begin
		case (req_opcode)
			opcode_a_get, opcode_a_arithmetic, opcode_a_logical: d_opcode = opcode_d_accessackdata;
			opcode_a_intent: d_opcode = opcode_d_hintack;
			default: d_opcode = opcode_d_accessack;
		endcase
	end

	assign d_size = req_size;
	assign d_source = req_source;
	assign d_error = req_err;
	assign d_data = rd_ok ? mem_rdata : '0; // errors carry zero data

	assign get_done = d_fire && d_last && rd_ok;
	assign put_done = d_fire && d_last && !req_err && is_put(req_opcode);
	assign err_done = d_fire && d_last && req_err;

	always_ff @(posedge clock) begin
		if (reset) begin
			phase <= ph_idle;
			beat <= '0;
			wait_cnt <= '0;
		end else begin
			case (phase)
				ph_collect: begin
					if (a_fire) begin
						if (beat == beats_m1(req_size)) begin
							beat <= '0;
							wait_cnt <= '0;
							phase <= start_phase;
						end else begin
							beat <= beat + 1'b1;
						end
					end
				end
				ph_wait: begin
					wait_cnt <= wait_cnt + 4'd1;
					if ({1'b0, wait_cnt} + 5'd1 >= {1'b0, wait_states})
						phase <= ph_fetch;
				end
				ph_fetch:
					phase <= ph_respond; // read issued this cycle
				ph_respond: begin
					if (d_fire) begin
						if (d_last) begin
							phase <= ph_idle;
						end else begin
							beat <= beat + 1'b1;
							wait_cnt <= '0;
							phase <= start_phase;
						end
					end
				end
				default: ;
			endcase

			if (start_new) begin
				wait_cnt <= '0;
				if (a_has_data(a_opcode) && beats_m1(a_size) != '0) begin
					beat <= 1; // first beat taken here
					phase <= ph_collect;
				end else begin
					beat <= '0;
					phase <= start_phase;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start_new) begin
			req_opcode <= a_opcode;
			req_size <= a_size;
			req_source <= a_source;
			req_addr <= a_address;
			req_err <= a_err;
		end
	end
endmodule

`default_nettype wire

// ==== verilog/tl_slave_regs.sv ====
`default_nettype none

module tl_slave_regs import tl_pkg::*; (
	input  logic        clock,
	input  logic        reset,

	input  logic [4:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,

	input  logic [4:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,

	input  logic        get_done,
	input  logic        put_done,
	input  logic        err_done,

	output logic        enable,
	output logic [3:0]  wait_states
);
	logic wr_fire, rd_fire, clear;
	logic [1:0] wr_resp, rd_resp;
	logic [31:0] rd_data;
	logic [2:0] done;
	logic [15:0] counts [3]; // get, put, err

	assign wr_fire = awvalid && wvalid && !bvalid;
	assign awready = wr_fire;
	assign wready = wr_fire;
	assign arready = !rvalid;
	assign rd_fire = arvalid && arready;

	assign clear = wr_fire && awaddr == reg_ctrl && wstrb[0] && wdata[1];
	assign done = {err_done, put_done, get_done};

	always_comb begin
		case (awaddr)
			reg_ctrl, reg_wait, reg_get_count, reg_put_count, reg_err_count:
				wr_resp = axi_resp_okay;
			default:
				wr_resp = axi_resp_slverr;
		endcase
	end

	always_comb begin
		rd_data = '0;
		rd_resp = axi_resp_okay;
		case (araddr)
			reg_ctrl:      rd_data = {31'd0, enable}; // clear bit reads 0
			reg_wait:      rd_data = {28'd0, wait_states};
			reg_get_count: rd_data = {16'd0, counts[0]};
			reg_put_count: rd_data = {16'd0, counts[1]};
			reg_err_count: rd_data = {16'd0, counts[2]};
			default:       rd_resp = axi_resp_slverr;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			enable <= 1'b1;
			wait_states <= '0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			for (int i = 0; i < 3; i++)
				counts[i] <= '0;
		end else begin
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (wr_fire)
				bvalid <= 1'b1;
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (rd_fire)
				rvalid <= 1'b1;

			if (wr_fire && wstrb[0]) begin
				if (awaddr == reg_ctrl)
					enable <= wdata[0];
				if (awaddr == reg_wait)
					wait_states <= wdata[3:0];
			end

			// saturating event counters
			for (int i = 0; i < 3; i++) begin
				if (clear)
					counts[i] <= '0;
				else if (done[i] && counts[i] != 16'hffff)
					counts[i] <= counts[i] + 16'd1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (wr_fire)
			bresp <= wr_resp;
		if (rd_fire) begin
			rdata <= rd_data;
			rresp <= rd_resp;
		end
	end
endmodule

`default_nettype wire

// ==== verilog/tl_mem_subsys.sv ====
`default_nettype none

module tl_mem_subsys import tl_pkg::*; #(
	parameter int mem_words    = 1024,
	parameter int source_width = 4
) (
	input  logic                     clock,
	input  logic                     reset,

	input  logic                     a_valid,
	output logic                     a_ready,
	input  logic [2:0]               a_opcode,
	input  logic [tl_size_width-1:0] a_size,
	input  logic [source_width-1:0]  a_source,
	input  logic [tl_addr_width-1:0] a_address,
	input  logic [tl_mask_width-1:0] a_mask,
	input  logic [tl_data_width-1:0] a_data,

	output logic                     d_valid,
	input  logic                     d_ready,
	output logic [2:0]               d_opcode,
	output logic [tl_size_width-1:0] d_size,
	output logic [source_width-1:0]  d_source,
	output logic [tl_data_width-1:0] d_data,
	output logic                     d_error,

	input  logic [4:0]               awaddr,
	input  logic                     awvalid,
	output logic                     awready,
	input  logic [31:0]              wdata,
	input  logic [3:0]               wstrb,
	input  logic                     wvalid,
	output logic                     wready,
	output logic [1:0]               bresp,
	output logic                     bvalid,
	input  logic                     bready,
	input  logic [4:0]               araddr,
	input  logic                     arvalid,
	output logic                     arready,
	output logic [31:0]              rdata,
	output logic [1:0]               rresp,
	output logic                     rvalid,
	input  logic                     rready
);
	logic mem_en, mem_we;
	logic [$clog2(mem_words)-1:0] mem_addr;
	logic [tl_mask_width-1:0] mem_wmask;
	logic [tl_data_width-1:0] mem_wdata, mem_rdata;
	logic enable;
	logic [3:0] wait_states;
	logic get_done, put_done, err_done;

	tl_ul_slave #(
		.mem_words    (mem_words),
		.source_width (source_width)
	) u_slave (
		.clock       (clock),
		.reset       (reset),
		.a_valid     (a_valid),
		.a_ready     (a_ready),
		.a_opcode    (a_opcode),
		.a_size      (a_size),
		.a_source    (a_source),
		.a_address   (a_address),
		.a_mask      (a_mask),
		.a_data      (a_data),
		.d_valid     (d_valid),
		.d_ready     (d_ready),
		.d_opcode    (d_opcode),
		.d_size      (d_size),
		.d_source    (d_source),
		.d_data      (d_data),
		.d_error     (d_error),
		.enable      (enable),
		.wait_states (wait_states),
		.mem_en      (mem_en),
		.mem_we      (mem_we),
		.mem_addr    (mem_addr),
		.mem_wmask   (mem_wmask),
		.mem_wdata   (mem_wdata),
		.mem_rdata   (mem_rdata),
		.get_done    (get_done),
		.put_done    (put_done),
		.err_done    (err_done)
	);

	tl_mem_array #(
		.mem_words (mem_words)
	) u_mem (
		.clock (clock),
		.en    (mem_en),
		.we    (mem_we),
		.addr  (mem_addr),
		.wmask (mem_wmask),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

	tl_slave_regs u_regs (
		.clock       (clock),
		.reset       (reset),
		.awaddr      (awaddr),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.wvalid      (wvalid),
		.wready      (wready),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.bready      (bready),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rresp       (rresp),
		.rvalid      (rvalid),
		.rready      (rready),
		.get_done    (get_done),
		.put_done    (put_done),
		.err_done    (err_done),
		.enable      (enable),
		.wait_states (wait_states)
	);
endmodule

`default_nettype wire

// ==== sim/tb_tl_mem_subsys.sv ====
`default_nettype none

module tb_tl_mem_subsys import tl_pkg::*; ();
	localparam int wait_limit = 400;

	logic clock, reset;
	logic a_valid, a_ready, d_valid, d_ready, d_error;
	logic [2:0] a_opcode, d_opcode;
	logic [3:0] a_size, d_size, a_source, d_source, a_mask;
	logic [31:0] a_address, a_data, d_data;
	logic [4:0] awaddr, araddr;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [31:0] wdata, rdata;
	logic [3:0] wstrb;
	logic [1:0] bresp, rresp;

	logic [31:0] lfsr = 32'ha8fb8c71;
	logic [31:0] shadow [1024];
	logic [3:0] known [1024]; // bytes written so far
	int errors = 0, checks = 0, tests = 0;
	int gets = 0, puts = 0, errs = 0;
	int wait_n = 0;

	// monitor state
	int cyc, last_evt;
	logic prev_dv, prev_fire, stall;
	logic [43:0] held;

	tl_mem_subsys #(
		.mem_words    (1024),
		.source_width (4)
	) u_tl_mem_subsys (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [31:0] byte_bits(input logic [3:0] m);
		return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
	endfunction

	function automatic logic [3:0] full_mask(input logic [3:0] size, input logic [31:0] addr);
		if (size == 4'd0)
			return 4'b0001 << addr[1:0];
		if (size == 4'd1)
			return addr[1] ? 4'hc : 4'h3;
		return 4'hf;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout while waiting for %s", what);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	task automatic test_done(input string name);
		tests++;
		$display("test %s finished, %0d errors so far", name, errors);
	endtask

	task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
			input logic [1:0] exp_resp);
		int t;
		t = 0;
		awaddr <= addr;
		wdata <= data;
		wstrb <= 4'hf;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		@(posedge clock);
		while (!awready) begin
			t++;
			if (t > wait_limit)
				timeout_fail("awready");
			@(posedge clock);
		end
		check_val("wready", 32'(wready), 32'd1);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		t = 0;
		@(posedge clock);
		while (!bvalid) begin
			t++;
			if (t > wait_limit)
				timeout_fail("bvalid");
			@(posedge clock);
		end
		check_val("bresp", 32'(bresp), 32'(exp_resp));
		if (addr == reg_wait)
			wait_n = int'(data[3:0]);
	endtask

	task automatic axi_read(input logic [4:0] addr, input logic [31:0] exp_data,
			input logic [1:0] exp_resp);
		int t;
		t = 0;
		araddr <= addr;
		arvalid <= 1'b1;
		@(posedge clock);
		while (!arready) begin
			t++;
			if (t > wait_limit)
				timeout_fail("arready");
			@(posedge clock);
		end
		arvalid <= 1'b0;
		t = 0;
		@(posedge clock);
		while (!rvalid) begin
			t++;
			if (t > wait_limit)
				timeout_fail("rvalid");
			@(posedge clock);
		end
		check_val("rdata", rdata, exp_data);
		check_val("rresp", 32'(rresp), 32'(exp_resp));
	endtask

	task automatic tl_request(input logic [2:0] op, input logic [3:0] size,
			input logic [31:0] addr, input logic exp_err);
		int a_beats, d_beats, t, beat;
		logic [31:0] data, baddr;
		logic [3:0] mask, src;
		logic [2:0] exp_op;
		logic a_data_op, d_data_op;
		a_data_op = op <= opcode_a_logical;
		d_data_op = op == opcode_a_get || op == opcode_a_arithmetic || op == opcode_a_logical;
		a_beats = (a_data_op && size > 4'd2) ? 1 << (size - 4'd2) : 1;
		d_beats = (d_data_op && size > 4'd2) ? 1 << (size - 4'd2) : 1;
		exp_op = d_data_op ? opcode_d_accessackdata
			: (op == opcode_a_intent ? opcode_d_hintack : opcode_d_accessack);
		src = 4'(take_bits(4));
		for (beat = 0; beat < a_beats; beat++) begin
			baddr = addr + 32'(beat * 4);
			data = take_bits(32);
			mask = (op == opcode_a_putpartial) ? 4'(take_bits(4)) : full_mask(size, addr);
			a_valid <= 1'b1;
			a_opcode <= op;
			a_size <= size;
			a_source <= src;
			a_address <= addr;
			a_mask <= mask;
			a_data <= data;
			t = 0;
			@(posedge clock);
			while (!a_ready) begin
				t++;
				if (t > wait_limit)
					timeout_fail("a_ready");
				@(posedge clock);
			end
			if (op <= opcode_a_putpartial && !exp_err) begin
				for (int k = 0; k < 4; k++) begin
					if (mask[k]) begin
						shadow[baddr[11:2]][8*k +: 8] = data[8*k +: 8];
						known[baddr[11:2]][k] = 1'b1;
					end
				end
			end
		end
		a_valid <= 1'b0;

		beat = 0;
		t = 0;
		d_ready <= take_bits(2) != 0; // roughly one stall in four
		while (beat < d_beats) begin
			@(posedge clock);
			if (d_valid && d_ready) begin
				baddr = addr + 32'(beat * 4);
				check_val("d_opcode", 32'(d_opcode), 32'(exp_op));
				check_val("d_size", 32'(d_size), 32'(size));
				check_val("d_source", 32'(d_source), 32'(src));
				check_val("d_error", 32'(d_error), 32'(exp_err));
				if (exp_err)
					check_val("d_data", d_data, 32'd0);
				else if (d_data_op)
					check_val("d_data", d_data & byte_bits(known[baddr[11:2]]),
						shadow[baddr[11:2]] & byte_bits(known[baddr[11:2]]));
				beat++;
				t = 0;
			end else begin
				t++;
				if (t > wait_limit)
					timeout_fail("d_valid");
			end
			d_ready <= take_bits(2) != 0;
		end
		d_ready <= 1'b0;
		@(posedge clock);
		check_val("d_valid after last beat", 32'(d_valid), 32'd0);

		if (exp_err)
			errs++;
		else if (op == opcode_a_get)
			gets++;
		else
			puts++;
	endtask

	// stall stability and wait-state spacing
	always @(posedge clock) begin
		if (reset) begin
			cyc = 0;
			last_evt = 0;
			prev_dv = 1'b0;
			prev_fire = 1'b0;
			stall = 1'b0;
		end else begin
			cyc++;
			if (stall) begin
				check_val("d_valid under stall", 32'(d_valid), 32'd1);
				check_val("d fields under stall", {20'd0, d_opcode, d_size, d_source, d_error},
					{20'd0, held[43:32]});
				check_val("d_data under stall", d_data, held[31:0]);
			end
			if (d_valid && (!prev_dv || prev_fire)) begin
				checks++;
				assert (cyc - last_evt >= wait_n + 1) else begin
					errors++;
					$display("D beat came %0d cycles after its start event, wait states %0d",
						cyc - last_evt, wait_n);
				end
			end
			prev_dv = d_valid;
			prev_fire = d_valid && d_ready;
			stall = d_valid && !d_ready;
			held = {d_opcode, d_size, d_source, d_error, d_data};
			if ((a_valid && a_ready) || (d_valid && d_ready))
				last_evt = cyc;
		end
	end

	initial begin
		logic [31:0] addr;
		logic [3:0] size;
		for (int i = 0; i < 1024; i++)
			known[i] = 4'h0;
		reset = 1'b1;
		a_valid = 1'b0;
		a_opcode = '0;
		a_size = '0;
		a_source = '0;
		a_address = '0;
		a_mask = '0;
		a_data = '0;
		d_ready = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b1;

		for (int i = 0; i < 16; i++) begin
			@(posedge clock);
			if (i > 1)
				check_val("a_ready/d_valid/bvalid/rvalid in reset",
					{28'd0, a_ready, d_valid, bvalid, rvalid}, 32'd0);
		end
		reset <= 1'b0;
		@(posedge clock);
		check_val("d_valid/bvalid/rvalid after reset",
			{29'd0, d_valid, bvalid, rvalid}, 32'd0);
		axi_read(reg_ctrl, 32'd1, axi_resp_okay);
		axi_read(reg_wait, 32'd0, axi_resp_okay);
		axi_read(reg_get_count, 32'd0, axi_resp_okay);
		axi_read(reg_put_count, 32'd0, axi_resp_okay);
		axi_read(reg_err_count, 32'd0, axi_resp_okay);
		test_done("reset");

		for (int i = 0; i < 14; i++) begin
			size = 4'(i % 7);
			addr = take_bits(12) & ~((32'd1 << size) - 32'd1);
			tl_request(opcode_a_putfull, size, addr, 1'b0);
			tl_request(opcode_a_get, size, addr, 1'b0);
		end
		test_done("put/get round trip");

		for (int i = 0; i < 4; i++) begin
			addr = take_bits(12) & 32'hff8;
			tl_request(opcode_a_putfull, 4'd3, addr, 1'b0);
			tl_request(opcode_a_putpartial, 4'd3, addr, 1'b0);
			tl_request(opcode_a_get, 4'd3, addr, 1'b0);
		end
		test_done("partial put");

		axi_write(reg_wait, 32'd3, axi_resp_okay);
		for (int i = 0; i < 3; i++) begin
			addr = take_bits(12) & 32'hff0;
			tl_request(opcode_a_putfull, 4'd4, addr, 1'b0);
			tl_request(opcode_a_get, 4'd4, addr, 1'b0);
		end
		axi_write(reg_wait, 32'd0, axi_resp_okay);
		test_done("wait states and stalls");

		tl_request(opcode_a_putfull, 4'd3, 32'h0ff8, 1'b0);
		tl_request(opcode_a_putfull, 4'd4, 32'h0ff8, 1'b1); // runs past the end
		tl_request(opcode_a_get, 4'd3, 32'h0ff8, 1'b0);
		tl_request(opcode_a_get, 4'd2, 32'h1000, 1'b1);
		tl_request(opcode_a_get, 4'd7, 32'h0, 1'b1);
		tl_request(opcode_a_arithmetic, 4'd3, 32'h0, 1'b1);
		tl_request(opcode_a_logical, 4'd2, 32'h0, 1'b1);
		tl_request(opcode_a_intent, 4'd2, 32'h0, 1'b1);
		axi_read(5'h14, 32'd0, axi_resp_slverr);
		test_done("errors");

		axi_read(reg_get_count, 32'(gets), axi_resp_okay);
		axi_read(reg_put_count, 32'(puts), axi_resp_okay);
		axi_read(reg_err_count, 32'(errs), axi_resp_okay);
		axi_write(reg_ctrl, 32'd3, axi_resp_okay); // clear, stay enabled
		axi_read(reg_get_count, 32'd0, axi_resp_okay);
		axi_read(reg_put_count, 32'd0, axi_resp_okay);
		axi_read(reg_err_count, 32'd0, axi_resp_okay);
		gets = 0;
		puts = 0;
		errs = 0;

		axi_write(reg_ctrl, 32'd0, axi_resp_okay);
		a_valid <= 1'b1;
		a_opcode <= opcode_a_get;
		a_size <= 4'd2;
		a_address <= 32'h0ff8;
		for (int i = 0; i < 10; i++) begin
			@(posedge clock);
			if (i > 0)
				check_val("a_ready while disabled", 32'(a_ready), 32'd0);
		end
		a_valid <= 1'b0;
		axi_write(reg_ctrl, 32'd1, axi_resp_okay);
		tl_request(opcode_a_get, 4'd2, 32'h0ff8, 1'b0);
		axi_read(reg_get_count, 32'(gets), axi_resp_okay);
		axi_read(reg_put_count, 32'(puts), axi_resp_okay);
		test_done("counters and enable");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end
endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/tl_pkg.sv
verilog/tl_mem_array.sv
verilog/tl_ul_slave.sv
verilog/tl_slave_regs.sv
verilog/tl_mem_subsys.sv
sim/tb_tl_mem_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; pass or fail comes from the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_tl_mem_subsys \
	-o tb_tl_mem_subsys
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_tl_mem_subsys > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation finished: PASS$" sim.log; then
	exit 0
fi
exit 1
